// ==== list.f ====
verilog/dcache_pkg.sv
verilog/way_store.sv
verilog/set_lookup.sv
verilog/dcache_ctrl.sv
verilog/dcache.sv
tests/dcache_mem_model.sv
tests/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  # Design sources in compile order
  - verilog/dcache_pkg.sv
  - verilog/way_store.sv
  - verilog/set_lookup.sv
  - verilog/dcache_ctrl.sv
  - verilog/dcache.sv

  # Simulation only
  - target: test
    files:
      - tests/dcache_mem_model.sv
      - tests/dcache_tb.sv

// ==== tests/dcache_tb.sv ====
// Testbench for the data cache with a memory model and checking assertions
`timescale 1ns/10ps

module dcache_tb;

	localparam int cycle_limit = 2000;
	localparam int req_limit   = 60;
	localparam int flush_limit = 100;

	logic              CLK;
	logic              nRST;
	logic              dmem_ren;
	logic              dmem_wen;
	dcache_pkg::word_t dmem_addr;
	dcache_pkg::word_t dmem_store;
	dcache_pkg::word_t dmem_load;
	logic              dhit;
	logic              halt;
	logic              flushed;
	logic              mem_ren;
	logic              mem_wen;
	dcache_pkg::word_t mem_addr;
	dcache_pkg::word_t mem_store;
	dcache_pkg::word_t mem_load;
	logic              mem_wait;
	dcache_pkg::word_t peek_addr;
	dcache_pkg::word_t peek_data;

	// Latest value of every word the core has written
	dcache_pkg::word_t core_words [dcache_pkg::word_t];

	int                errors = 0;
	int                proto_errors = 0;
	int                cycles = 0;
	int                mem_writes = 0;
	int                writes_before;
	int                start;
	int                waited;
	logic              hit_expected;
	logic              evict_pending;
	logic              peek_check;
	dcache_pkg::word_t evict_block;
	dcache_pkg::word_t a0;
	dcache_pkg::word_t a1;
	dcache_pkg::word_t b0;
	dcache_pkg::word_t c0;
	dcache_pkg::word_t d0;

	dcache dcache_inst (
		.CLK, .nRST,
		.dmem_ren, .dmem_wen, .dmem_addr, .dmem_store, .dmem_load, .dhit,
		.halt, .flushed,
		.mem_ren, .mem_wen, .mem_addr, .mem_store, .mem_load, .mem_wait
	);

	dcache_mem_model mem_inst (
		.CLK,
		.mem_ren, .mem_wen, .mem_addr, .mem_store, .mem_load, .mem_wait,
		.peek_addr, .peek_data
	);

	always #5 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles == cycle_limit) begin
			$display("Timeout: the run did not end within %0d cycles", cycle_limit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// Counts completed memory writes for the victim writeback check
	always @(posedge CLK) begin
		if (nRST && mem_wen && !mem_wait) begin
			mem_writes <= mem_writes + 1;
		end
	end

	// Memory holds addr ^ 5A5A0000 until the core writes the word
	function automatic dcache_pkg::word_t expected_word(input dcache_pkg::word_t addr);
		if (core_words.exists(addr)) begin
			return core_words[addr];
		end
		return addr ^ 32'h5A5A0000;
	endfunction

	function automatic dcache_pkg::word_t make_addr(input dcache_pkg::tag_t tag,
			input dcache_pkg::idx_t idx, input logic blkoff);
		dcache_pkg::dcache_addr_t a;
		a.tag = tag;
		a.idx = idx;
		a.blkoff = blkoff;
		a.byteoff = 2'b00;
		return a;
	endfunction

	// Drives one core request and holds it until the edge where dhit completes it
	task automatic access(input logic write, input dcache_pkg::word_t addr,
			input dcache_pkg::word_t data, input logic want_hit);
		int n;
		n = 0;
		hit_expected = want_hit;
		dmem_addr = addr;
		dmem_store = data;
		dmem_ren = !write;
		dmem_wen = write;
		@(negedge CLK);
		while (!dhit && n < req_limit) begin
			@(negedge CLK);
			n++;
		end
		if (!dhit) begin
			errors++;
			$display("Request to address %h got no dhit within %0d cycles", addr, req_limit);
		end
		@(posedge CLK);
		#1;
		if (write) begin
			core_words[addr] = data;
		end
		dmem_ren = 1'b0;
		dmem_wen = 1'b0;
		hit_expected = 1'b0;
	endtask

	task automatic check_memory();
		foreach (core_words[a]) begin
			peek_addr = a;
			peek_check = 1'b1;
			@(posedge CLK);
			#1;
		end
		peek_check = 1'b0;
	endtask

	task automatic report_test(input string name, input int first_errors);
		if (errors == first_errors) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: %0d failed checks", name, errors - first_errors);
		end
	endtask

	a_reset_state: assert property (@(posedge CLK)
		$past(!nRST) |-> !dhit && !flushed && !mem_ren && !mem_wen)
	else begin
		errors++;
		$display("Outputs were not all low right after reset");
	end

	a_load_value: assert property (@(posedge CLK) disable iff (!nRST)
		dhit && dmem_ren |-> dmem_load == expected_word(dmem_addr))
	else begin
		errors++;
		$display("FAIL dmem_load: got %h, expected %h",
			$sampled(dmem_load), expected_word($sampled(dmem_addr)));
	end

	a_expect_hit: assert property (@(posedge CLK) disable iff (!nRST)
		hit_expected && (dmem_ren || dmem_wen) |-> dhit && !mem_ren)
	else begin
		errors++;
		$display("A request to a cached block missed or read memory");
	end

	a_write_data: assert property (@(posedge CLK) disable iff (!nRST)
		mem_wen && !mem_wait |-> mem_store == expected_word(mem_addr))
	else begin
		errors++;
		$display("FAIL mem_store at %h: got %h, expected %h", $sampled(mem_addr),
			$sampled(mem_store), expected_word($sampled(mem_addr)));
	end

	a_evict_addr: assert property (@(posedge CLK) disable iff (!nRST)
		evict_pending && mem_wen |-> mem_addr[31:3] == evict_block[31:3])
	else begin
		errors++;
		$display("FAIL mem_addr: got %h, expected a word of block %h",
			$sampled(mem_addr), evict_block);
	end

	a_evict_count: assert property (@(posedge CLK) disable iff (!nRST)
		evict_pending && dhit |-> mem_writes == writes_before + 2)
	else begin
		errors++;
		$display("FAIL mem_wen writes: got %h, expected %h",
			$sampled(mem_writes) - writes_before, 2);
	end

	a_flushed_stays: assert property (@(posedge CLK) disable iff (!nRST)
		flushed |=> flushed)
	else begin
		errors++;
		$display("flushed dropped after it had risen");
	end

	a_flush_quiet: assert property (@(posedge CLK) disable iff (!nRST)
		flushed |-> !mem_ren && !mem_wen)
	else begin
		errors++;
		$display("The cache accessed memory after flushed rose");
	end

	a_memory_holds: assert property (@(posedge CLK) disable iff (!nRST)
		peek_check |-> peek_data == expected_word(peek_addr))
	else begin
		errors++;
		$display("FAIL memory word %h: got %h, expected %h", $sampled(peek_addr),
			$sampled(peek_data), expected_word($sampled(peek_addr)));
	end

	a_mem_excl: assert property (@(posedge CLK) disable iff (!nRST)
		!(mem_ren && mem_wen))
	else begin
		errors++;
		proto_errors++;
		$display("mem_ren and mem_wen were high together");
	end

	a_mem_stable: assert property (@(posedge CLK) disable iff (!nRST)
		(mem_ren || mem_wen) && mem_wait |=>
			$stable(mem_addr) && $stable(mem_ren) && $stable(mem_wen) && $stable(mem_store))
	else begin
		errors++;
		proto_errors++;
		$display("A memory access changed while mem_wait was high");
	end

	initial begin
		CLK = 1'b0;
		nRST = 1'b0;
		dmem_ren = 1'b0;
		dmem_wen = 1'b0;
		dmem_addr = '0;
		dmem_store = '0;
		halt = 1'b0;
		peek_addr = '0;
		peek_check = 1'b0;
		hit_expected = 1'b0;
		evict_pending = 1'b0;
		evict_block = '0;
		writes_before = 0;
		// Three tags share set 5, a fourth block sits in set 2
		a0 = make_addr(26'h1, 3'd5, 1'b0);
		a1 = make_addr(26'h1, 3'd5, 1'b1);
		b0 = make_addr(26'h2, 3'd5, 1'b0);
		c0 = make_addr(26'h3, 3'd5, 1'b0);
		d0 = make_addr(26'h7, 3'd2, 1'b0);

		repeat (5) @(posedge CLK);
		#1;
		nRST = 1'b1;
		start = errors;
		repeat (2) @(posedge CLK);
		#1;
		report_test("reset state", start);

		start = errors;
		access(1'b0, a0, '0, 1'b0);
		access(1'b0, a1, '0, 1'b1);
		report_test("read miss and refill", start);

		start = errors;
		access(1'b1, a0, 32'hA0A0_1111, 1'b1);
		access(1'b0, a0, '0, 1'b1);
		access(1'b0, a1, '0, 1'b1);
		report_test("write hit and reread", start);

		// NRU now points at way 1, so the write to B fills there and A goes next
		start = errors;
		access(1'b1, b0, 32'hB0B0_2222, 1'b0);
		writes_before = mem_writes;
		evict_block = a0;
		evict_pending = 1'b1;
		access(1'b1, c0, 32'hC0C0_3333, 1'b0);
		evict_pending = 1'b0;
		access(1'b0, a0, '0, 1'b0);
		report_test("dirty victim eviction", start);

		start = errors;
		access(1'b1, d0, 32'hD0D0_4444, 1'b0);
		halt = 1'b1;
		waited = 0;
		@(negedge CLK);
		while (!flushed && waited < flush_limit) begin
			@(negedge CLK);
			waited++;
		end
		if (!flushed) begin
			errors++;
			$display("flushed never rose within %0d cycles after halt", flush_limit);
		end
		repeat (4) @(posedge CLK);
		#1;
		check_memory();
		report_test("halt flush", start);

		if (proto_errors == 0) begin
			$display("test memory protocol: passed");
		end else begin
			$display("test memory protocol: %0d failed checks", proto_errors);
		end

		$display("%0d tests run, %0d failed checks", 6, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== tests/dcache_mem_model.sv ====
// Main memory model with random wait states, an address based fill pattern and a write log
`timescale 1ns/10ps

module dcache_mem_model (
	input  logic              CLK,
	input  logic              mem_ren,
	input  logic              mem_wen,
	input  dcache_pkg::word_t mem_addr,
	input  dcache_pkg::word_t mem_store,
	output dcache_pkg::word_t mem_load,
	output logic              mem_wait,
	input  dcache_pkg::word_t peek_addr,
	output dcache_pkg::word_t peek_data
);

	localparam int unsigned seed     = 32'h9866;
	localparam int unsigned max_wait = 2;

	// Only written words are kept here and every other address reads its fill pattern
	dcache_pkg::word_t words [dcache_pkg::word_t];
	logic [1:0]        wait_cnt;

	function automatic dcache_pkg::word_t fill_value(input dcache_pkg::word_t addr);
		return addr ^ 32'h5A5A0000;
	endfunction

	always_comb begin
		if (words.exists(mem_addr)) begin
			mem_load = words[mem_addr];
		end else begin
			mem_load = fill_value(mem_addr);
		end
	end

	// Side port for looking at the contents once the cache has flushed
	always_comb begin
		if (words.exists(peek_addr)) begin
			peek_data = words[peek_addr];
		end else begin
			peek_data = fill_value(peek_addr);
		end
	end

	assign mem_wait = (mem_ren || mem_wen) && (wait_cnt != 2'd0);

	// The wait count for the next access is drawn as the current one completes
	initial begin
		void'($urandom(seed));
		wait_cnt = 2'($urandom_range(max_wait, 0));
		forever begin
			@(posedge CLK);
			if (mem_ren || mem_wen) begin
				if (wait_cnt != 2'd0) begin
					wait_cnt <= wait_cnt - 2'd1;
				end else begin
					if (mem_wen) begin
						words[mem_addr] = mem_store;
					end
					wait_cnt <= 2'($urandom_range(max_wait, 0));
				end
			end
		end
	end

endmodule

// ==== verilog/dcache.sv ====
// Two-way set-associative write-back data cache top level
`timescale 1ns/10ps

module dcache (
	input  logic              CLK,
	input  logic              nRST,
	input  logic              dmem_ren,
	input  logic              dmem_wen,
	input  dcache_pkg::word_t dmem_addr,
	input  dcache_pkg::word_t dmem_store,
	output dcache_pkg::word_t dmem_load,
	output logic              dhit,
	input  logic              halt,
	output logic              flushed,
	output logic              mem_ren,
	output logic              mem_wen,
	output dcache_pkg::word_t mem_addr,
	output dcache_pkg::word_t mem_store,
	input  dcache_pkg::word_t mem_load,
	input  logic              mem_wait
);

	dcache_pkg::dcache_addr_t req;
	dcache_pkg::idx_t         rd_idx;
	dcache_pkg::word_t        wr_data;
	dcache_pkg::tag_t         way_tag [2];
	logic                     way_valid [2];
	logic                     way_dirty [2];
	dcache_pkg::word_t        way_word0 [2];
	dcache_pkg::word_t        way_word1 [2];
	logic [1:0]               fill_word_en;
	logic [1:0]               fill_done;
	logic [1:0]               store_en;
	logic [1:0]               clean_en;
	logic                     word_sel;
	logic                     hit;
	logic                     hit_way;
	logic                     victim_way;
	logic                     touch_en;
	logic                     drain_way;
	logic                     drain_sel;
	dcache_pkg::tag_t         drain_tag;
	logic                     drain_dirty;
	logic                     drain_valid;

	assign req = dmem_addr;

	// Stores take the core's word, fills take the memory's
	assign wr_data = (|store_en) ? dmem_store : mem_load;

	dcache_ctrl ctrl_inst (
		.CLK, .nRST,
		.dmem_ren, .dmem_wen, .dmem_addr, .halt,
		.hit, .hit_way, .victim_way,
		.drain_tag, .drain_dirty, .drain_valid,
		.mem_wait, .dhit, .flushed,
		.mem_ren, .mem_wen, .mem_addr,
		.rd_idx, .touch_en, .drain_way, .drain_sel,
		.fill_word_en, .fill_done, .store_en, .clean_en,
		.word_sel
	);

	for (genvar w = 0; w < 2; w++) begin : g_way
		way_store way_inst (
			.CLK, .nRST,
			.rd_idx       (rd_idx),
			.wr_idx       (rd_idx),
			.fill_word_en (fill_word_en[w]),
			.fill_done    (fill_done[w]),
			.store_en     (store_en[w]),
			.clean_en     (clean_en[w]),
			.word_sel     (word_sel),
			.wr_tag       (req.tag),
			.wr_data      (wr_data),
			.tag          (way_tag[w]),
			.valid        (way_valid[w]),
			.dirty        (way_dirty[w]),
			.word0        (way_word0[w]),
			.word1        (way_word1[w])
		);
	end

	// The controller's drain way doubles as the way to mark used
	set_lookup lookup_inst (
		.CLK, .nRST,
		.idx         (rd_idx),
		.req_tag     (req.tag),
		.blkoff      (req.blkoff),
		.tag0        (way_tag[0]),
		.valid0      (way_valid[0]),
		.dirty0      (way_dirty[0]),
		.w0_0        (way_word0[0]),
		.w0_1        (way_word1[0]),
		.tag1        (way_tag[1]),
		.valid1      (way_valid[1]),
		.dirty1      (way_dirty[1]),
		.w1_0        (way_word0[1]),
		.w1_1        (way_word1[1]),
		.touch_en    (touch_en),
		.touch_way   (drain_way),
		.drain_way   (drain_way),
		.drain_sel   (drain_sel),
		.hit         (hit),
		.hit_way     (hit_way),
		.victim_way  (victim_way),
		.load_word   (dmem_load),
		.drain_tag   (drain_tag),
		.drain_dirty (drain_dirty),
		.drain_valid (drain_valid),
		.drain_word  (mem_store)
	);

endmodule

// ==== verilog/dcache_ctrl.sv ====
// Data cache controller FSM for hits, victim writeback, block fill and the halt flush
`timescale 1ns/10ps

module dcache_ctrl (
	input  logic              CLK,
	input  logic              nRST,
	input  logic              dmem_ren,
	input  logic              dmem_wen,
	input  dcache_pkg::word_t dmem_addr,
	input  logic              halt,
	input  logic              hit,
	input  logic              hit_way,
	input  logic              victim_way,
	input  dcache_pkg::tag_t  drain_tag,
	input  logic              drain_dirty,
	input  logic              drain_valid,
	input  logic              mem_wait,
	output logic              dhit,
	output logic              flushed,
	output logic              mem_ren,
	output logic              mem_wen,
	output dcache_pkg::word_t mem_addr,
	output dcache_pkg::idx_t  rd_idx,
	output logic              touch_en,
	output logic              drain_way,
	output logic              drain_sel,
	output logic [1:0]        fill_word_en,
	output logic [1:0]        fill_done,
	output logic [1:0]        store_en,
	output logic [1:0]        clean_en,
	output logic              word_sel
);

	localparam int frame_width = $clog2(dcache_pkg::flush_frames);

	dcache_pkg::ctrl_state_t  state;
	dcache_pkg::ctrl_state_t  next_state;
	logic [frame_width-1:0]   frame;
	logic [frame_width-1:0]   next_frame;
	dcache_pkg::dcache_addr_t req;
	dcache_pkg::dcache_addr_t addr_out;
	dcache_pkg::idx_t         frame_idx;
	logic                     frame_way;
	logic                     last_frame;
	logic                     req_valid;
	logic                     victim_dirty;

	assign req = dmem_addr;
	assign req_valid = dmem_ren || dmem_wen;
	assign victim_dirty = drain_valid && drain_dirty;

	// Frames 0 to 7 walk way 0, frames 8 to 15 walk way 1
	assign frame_idx  = frame[dcache_pkg::idx_width-1:0];
	assign frame_way  = frame[frame_width-1];
	assign last_frame = (frame == frame_width'(dcache_pkg::flush_frames - 1));

	assign flushed  = (state == dcache_pkg::HALTED);
	assign mem_addr = addr_out;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= dcache_pkg::IDLE;
			frame <= '0;
		end else begin
			state <= next_state;
			frame <= next_frame;
		end
	end

	always_comb begin
		next_state   = state;
		next_frame   = frame;
		dhit         = 1'b0;
		mem_ren      = 1'b0;
		mem_wen      = 1'b0;
		addr_out     = '0;
		rd_idx       = req.idx;
		touch_en     = 1'b0;
		drain_way    = victim_way;
		drain_sel    = 1'b0;
		word_sel     = req.blkoff;
		fill_word_en = '0;
		fill_done    = '0;
		store_en     = '0;
		clean_en     = '0;

		case (state)
			dcache_pkg::IDLE: begin
				// The hit way also names the way to touch in the NRU
				drain_way = hit ? hit_way : victim_way;
				if (halt) begin
					next_state = dcache_pkg::FLUSH_SCAN;
				end else if (req_valid) begin
					if (hit) begin
						dhit = 1'b1;
						touch_en = 1'b1;
						if (dmem_wen) begin
							store_en[hit_way] = 1'b1;
						end
					end else if (victim_dirty) begin
						next_state = dcache_pkg::WB1;
					end else begin
						next_state = dcache_pkg::FILL1;
					end
				end
			end

			dcache_pkg::WB1, dcache_pkg::WB2: begin
				mem_wen = 1'b1;
				drain_sel = (state == dcache_pkg::WB2);
				addr_out.tag = drain_tag;
				addr_out.idx = req.idx;
				addr_out.blkoff = drain_sel;
				if (!mem_wait) begin
					next_state = (state == dcache_pkg::WB1) ? dcache_pkg::WB2 : dcache_pkg::FILL1;
				end
			end

			dcache_pkg::FILL1, dcache_pkg::FILL2: begin
				mem_ren = 1'b1;
				word_sel = (state == dcache_pkg::FILL2);
				addr_out.tag = req.tag;
				addr_out.idx = req.idx;
				addr_out.blkoff = word_sel;
				if (!mem_wait) begin
					if (state == dcache_pkg::FILL1) begin
						fill_word_en[victim_way] = 1'b1;
						next_state = dcache_pkg::FILL2;
					end else begin
						// Last word lands with the tag and valid bit
						fill_done[victim_way] = 1'b1;
						touch_en = 1'b1;
						next_state = dcache_pkg::IDLE;
					end
				end
			end

			dcache_pkg::FLUSH_SCAN: begin
				rd_idx = frame_idx;
				drain_way = frame_way;
				if (victim_dirty) begin
					next_state = dcache_pkg::FLUSH_WR1;
				end else if (last_frame) begin
					next_state = dcache_pkg::HALTED;
				end else begin
					next_frame = frame + 1'b1;
				end
			end

			dcache_pkg::FLUSH_WR1, dcache_pkg::FLUSH_WR2: begin
				rd_idx = frame_idx;
				drain_way = frame_way;
				mem_wen = 1'b1;
				drain_sel = (state == dcache_pkg::FLUSH_WR2);
				addr_out.tag = drain_tag;
				addr_out.idx = frame_idx;
				addr_out.blkoff = drain_sel;
				if (!mem_wait) begin
					if (state == dcache_pkg::FLUSH_WR1) begin
						next_state = dcache_pkg::FLUSH_WR2;
					end else begin
						clean_en[frame_way] = 1'b1;
						if (last_frame) begin
							next_state = dcache_pkg::HALTED;
						end else begin
							next_frame = frame + 1'b1;
							next_state = dcache_pkg::FLUSH_SCAN;
						end
					end
				end
			end

			dcache_pkg::HALTED: begin
				rd_idx = frame_idx;
			end

			default: begin
				next_state = dcache_pkg::IDLE;
			end
		endcase
	end

	// An access that is stalled must look the same on the next edge
	a_mem_hold: assert property (@(posedge CLK) disable iff (!nRST)
		(mem_ren || mem_wen) && mem_wait |=>
			$stable(mem_addr) && $stable(mem_ren) && $stable(mem_wen));

endmodule

// ==== verilog/set_lookup.sv ====
// Set lookup with tag compare, load word select, NRU replacement bits and drain readout
`timescale 1ns/10ps

module set_lookup (
	input  logic              CLK,
	input  logic              nRST,
	input  dcache_pkg::idx_t  idx,
	input  dcache_pkg::tag_t  req_tag,
	input  logic              blkoff,
	input  dcache_pkg::tag_t  tag0,
	input  logic              valid0,
	input  logic              dirty0,
	input  dcache_pkg::word_t w0_0,
	input  dcache_pkg::word_t w0_1,
	input  dcache_pkg::tag_t  tag1,
	input  logic              valid1,
	input  logic              dirty1,
	input  dcache_pkg::word_t w1_0,
	input  dcache_pkg::word_t w1_1,
	input  logic              touch_en,
	input  logic              touch_way,
	input  logic              drain_way,
	input  logic              drain_sel,
	output logic              hit,
	output logic              hit_way,
	output logic              victim_way,
	output dcache_pkg::word_t load_word,
	output dcache_pkg::tag_t  drain_tag,
	output logic              drain_dirty,
	output logic              drain_valid,
	output dcache_pkg::word_t drain_word
);

	logic [dcache_pkg::num_sets-1:0] nru;
	logic                            hit0;
	logic                            hit1;
	dcache_pkg::word_t               drain_w0;
	dcache_pkg::word_t               drain_w1;

	assign hit0 = valid0 && (tag0 == req_tag);
	assign hit1 = valid1 && (tag1 == req_tag);

	assign hit     = hit0 || hit1;
	assign hit_way = hit1;

	// A set bit means way 0 was used last, so way 1 goes next
	assign victim_way = nru[idx];

	always_comb begin
		if (hit_way) begin
			load_word = blkoff ? w1_1 : w1_0;
		end else begin
			load_word = blkoff ? w0_1 : w0_0;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			nru <= '0;
		end else if (touch_en) begin
			nru[idx] <= !touch_way;
		end
	end

	// Fields of the way that is being written back or flushed
	assign drain_tag   = drain_way ? tag1 : tag0;
	assign drain_valid = drain_way ? valid1 : valid0;
	assign drain_dirty = drain_way ? dirty1 : dirty0;
	assign drain_w0    = drain_way ? w1_0 : w0_0;
	assign drain_w1    = drain_way ? w1_1 : w0_1;
	assign drain_word  = drain_sel ? drain_w1 : drain_w0;

	// Fills only happen on a miss, so one block never lives in both ways
	a_single_hit: assert property (@(posedge CLK) disable iff (!nRST)
		!(hit0 && hit1));

endmodule

// ==== verilog/way_store.sv ====
// Storage for one cache way: tag, valid, dirty and the two data words of every set
`timescale 1ns/10ps

module way_store (
	input  logic                 CLK,
	input  logic                 nRST,
	input  dcache_pkg::idx_t     rd_idx,
	input  dcache_pkg::idx_t     wr_idx,
	input  logic                 fill_word_en,
	input  logic                 fill_done,
	input  logic                 store_en,
	input  logic                 clean_en,
	input  logic                 word_sel,
	input  dcache_pkg::tag_t     wr_tag,
	input  dcache_pkg::word_t    wr_data,
	output dcache_pkg::tag_t     tag,
	output logic                 valid,
	output logic                 dirty,
	output dcache_pkg::word_t    word0,
	output dcache_pkg::word_t    word1
);

	logic [dcache_pkg::num_sets-1:0] valid_bits;
	logic [dcache_pkg::num_sets-1:0] dirty_bits;
	dcache_pkg::tag_t                tags [dcache_pkg::num_sets];
	dcache_pkg::word_t               data [dcache_pkg::num_sets][dcache_pkg::words_per_block];
	logic                            word_wr;

	// Both fill strobes and a store put one word into the block
	assign word_wr = fill_word_en || fill_done || store_en;

	// Status bits per set
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else begin
			// A completed fill leaves the block clean, a write miss dirties it
			// with the store that follows the fill
			if (fill_done) begin
				valid_bits[wr_idx] <= 1'b1;
				dirty_bits[wr_idx] <= 1'b0;
			end
			if (store_en) begin
				dirty_bits[wr_idx] <= 1'b1;
			end
			if (clean_en) begin
				dirty_bits[wr_idx] <= 1'b0;
			end
		end
	end

	// Tag and data arrays
	always_ff @(posedge CLK) begin
		if (word_wr) begin
			data[wr_idx][word_sel] <= wr_data;
		end
		if (fill_done) begin
			tags[wr_idx] <= wr_tag;
		end
	end

	assign tag   = tags[rd_idx];
	assign valid = valid_bits[rd_idx];
	assign dirty = dirty_bits[rd_idx];
	assign word0 = data[rd_idx][0];
	assign word1 = data[rd_idx][1];

	// The controller issues at most one update to a way per cycle
	a_one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
		$onehot0({fill_word_en, fill_done, store_en, clean_en}));

endmodule

// ==== verilog/dcache_pkg.sv ====
// Data cache package with the cache geometry, the address layout and the controller states
package dcache_pkg;

	// Geometry of the two-way cache
	localparam int word_width      = 32;
	localparam int num_sets        = 8;
	localparam int idx_width       = 3;
	localparam int tag_width       = 26;
	localparam int words_per_block = 2;

	// The flush walks one frame per way per set
	localparam int flush_frames = 2 * num_sets;

	typedef logic [word_width-1:0] word_t;
	typedef logic [tag_width-1:0]  tag_t;
	typedef logic [idx_width-1:0]  idx_t;

	// Byte address as the cache sees it with the tag in the upper bits
	typedef struct packed {
		tag_t       tag;
		idx_t       idx;
		logic       blkoff;
		logic [1:0] byteoff;
	} dcache_addr_t;

	// Nine states need a four bit encoding
	typedef enum logic [3:0] {
		IDLE,
		WB1,
		WB2,
		FILL1,
		FILL2,
		FLUSH_SCAN,
		FLUSH_WR1,
		FLUSH_WR2,
		HALTED
	} ctrl_state_t;

endpackage
